// ==== design/acq_control.sv ====
`timescale 1ns/1ps

module acq_control #(
   parameter int BUF_ADDR_BITS = tart_cfg_pkg::BUF_ADDR_BITS_DEFAULT,
   parameter int RESET_CYCLES  = tart_cfg_pkg::RESET_CYCLES_DEFAULT
) (
   input  logic                    clk_x,
   input  logic                    reset,
   input  logic                    reg_wr_i,
   input  logic                    reg_rd_i,
   input  tart_cfg_pkg::reg_addr_t reg_addr_i,
   input  tart_cfg_pkg::byte_t     reg_wdata_i,
   capture_if.ctrl                 cap,
   buffer_if.ctrl                  bb,
   output logic                    rd_pulse_o,
   output logic [1:0]              data_sel_o,   // Byte within the sample
   output logic                    data_rd_o,    // Sample byte, not a register
   output tart_cfg_pkg::byte_t     reg_val_o,
   output logic                    led_o
);

   localparam int RST_BITS = $clog2(RESET_CYCLES + 1);

   tart_regs_pkg::acq_state_t state;
   tart_cfg_pkg::delay_t      delay_q;
   logic                      debug_q;
   logic                      start_q;
   logic [RST_BITS-1:0]       rst_cnt;
   logic [BUF_ADDR_BITS-1:0]  wr_addr_q;
   logic [BUF_ADDR_BITS-1:0]  rd_addr_q;
   logic                      rst_wr, soft_rst, clr;
   logic                      data_addr, data_ok, data_req, hi_rd, last_rd;
   logic                      start_go, last_wr;
   tart_cfg_pkg::byte_t       status, reg_val;

   // ------------------------------------------------------------
   // Host decode
   // ------------------------------------------------------------
   assign rst_wr    = reg_wr_i && (reg_addr_i == tart_regs_pkg::ADDR_RESET);
   assign soft_rst  = (rst_cnt != '0);
   assign clr       = reset || soft_rst || rst_wr;   // Clears control state
   assign data_addr = (reg_addr_i == tart_regs_pkg::ADDR_DATA_LO) ||
                      (reg_addr_i == tart_regs_pkg::ADDR_DATA_MID) ||
                      (reg_addr_i == tart_regs_pkg::ADDR_DATA_HI);
   assign data_ok   = (state == tart_regs_pkg::ST_READY) ||
                      (state == tart_regs_pkg::ST_READING);
   assign data_req  = reg_rd_i && data_addr && data_ok;
   assign hi_rd     = data_req && (reg_addr_i == tart_regs_pkg::ADDR_DATA_HI);
   assign last_rd   = hi_rd && (rd_addr_q == '1);        // Final byte of the block
   assign start_go  = reg_wr_i && (reg_addr_i == tart_regs_pkg::ADDR_START) &&
                      reg_wdata_i[0] && (state == tart_regs_pkg::ST_IDLE);
   assign last_wr   = bb.wr_en && (wr_addr_q == '1);

   // Soft reset stretcher
   always_ff @(posedge clk_x) begin
      if (reset) begin
         rst_cnt <= '0;
      end else if (rst_wr) begin
         rst_cnt <= RST_BITS'(RESET_CYCLES);
      end else if (soft_rst) begin
         rst_cnt <= rst_cnt - 1'b1;
      end
   end

   // Register bank
   always_ff @(posedge clk_x) begin
      if (clr) begin
         delay_q <= '0;
         debug_q <= 1'b0;
         start_q <= 1'b0;
      end else begin
         if (reg_wr_i && (reg_addr_i == tart_regs_pkg::ADDR_SAMPLE_DELAY))
            delay_q <= reg_wdata_i[tart_cfg_pkg::DELAY_BITS-1:0];
         if (reg_wr_i && (reg_addr_i == tart_regs_pkg::ADDR_DEBUG))
            debug_q <= reg_wdata_i[0];
         if (start_go)
            start_q <= 1'b1;
         else if (last_rd)
            start_q <= 1'b0;     // Block fully read back
      end
   end

   // ------------------------------------------------------------
   // Acquisition FSM and buffer addressing
   // ------------------------------------------------------------
   always_ff @(posedge clk_x) begin
      if (clr) begin
         state     <= tart_regs_pkg::ST_IDLE;
         wr_addr_q <= '0;
         rd_addr_q <= '0;
      end else begin
         if (start_go) wr_addr_q <= '0;
         else if (bb.wr_en) wr_addr_q <= wr_addr_q + 1'b1;
         if (hi_rd) rd_addr_q <= rd_addr_q + 1'b1;   // Wraps to 0 after the last
         case (state)
            tart_regs_pkg::ST_IDLE:    if (start_go) state <= tart_regs_pkg::ST_ACQUIRE;
            tart_regs_pkg::ST_ACQUIRE: if (last_wr) state <= tart_regs_pkg::ST_READY;
            tart_regs_pkg::ST_READY:   if (data_req) state <= tart_regs_pkg::ST_READING;
            tart_regs_pkg::ST_READING: if (last_rd) state <= tart_regs_pkg::ST_IDLE;
            default:                   state <= tart_regs_pkg::ST_IDLE;
         endcase
      end
   end

   assign bb.wr_en   = (state == tart_regs_pkg::ST_ACQUIRE) && cap.strobe;
   assign bb.wr_addr = wr_addr_q;
   assign bb.rd_addr = rd_addr_q;
   assign cap.sample_delay = delay_q;
   assign cap.debug_mode   = debug_q;
   assign led_o = data_ok;    // Block available

   // Status byte
   always_comb begin
      status = '0;
      status[tart_regs_pkg::STAT_ONE]   = 1'b1;
      status[tart_regs_pkg::STAT_START] = start_q;
      status[tart_regs_pkg::STAT_DEBUG] = debug_q;
      status[2:0] = state;
   end

   // Register read mux, data addresses read as 0 here
   always_comb begin
      case (reg_addr_i)
         tart_regs_pkg::ADDR_SAMPLE_DELAY: reg_val = tart_cfg_pkg::byte_t'(delay_q);
         tart_regs_pkg::ADDR_DEBUG:        reg_val = tart_cfg_pkg::byte_t'(debug_q);
         tart_regs_pkg::ADDR_START:        reg_val = tart_cfg_pkg::byte_t'(start_q);
         tart_regs_pkg::ADDR_STATUS:       reg_val = status;
         default:                          reg_val = '0;
      endcase
   end

   // Read request staged for the fetch cycle
   always_ff @(posedge clk_x) begin
      if (reset) rd_pulse_o <= 1'b0;
      else       rd_pulse_o <= reg_rd_i;
   end

   always_ff @(posedge clk_x) begin
      data_sel_o <= reg_addr_i[1:0];   // LO, MID, HI map to 0, 1, 2
      data_rd_o  <= data_req;
      reg_val_o  <= reg_val;
   end

endmodule

// ==== design/antenna_capture.sv ====
`timescale 1ns/1ps

module antenna_capture (
   input  logic                  clk_x,
   input  logic                  reset,
   input  tart_cfg_pkg::sample_t antenna_i,
   capture_if.capt               cap
);

   tart_cfg_pkg::sample_t ant_q;    // Registered pins
   tart_cfg_pkg::sample_t fake_q;   // Debug counter

   // ------------------------------------------------------------
   // Input register
   // ------------------------------------------------------------
   // Sampled every clock, lags the pins by one cycle
   always_ff @(posedge clk_x) begin
      ant_q <= antenna_i;
   end

   // ------------------------------------------------------------
   // Fake telescope
   // ------------------------------------------------------------
   // Steps once per sample strobe, wraps at 2^24
   always_ff @(posedge clk_x) begin
      if (reset) begin
         fake_q <= '0;
      end else if (cap.strobe) begin
         fake_q <= fake_q + 1'b1;
      end
   end

   // Source select
   assign cap.sample = cap.debug_mode ? fake_q : ant_q;

endmodule

// ==== design/host_readback.sv ====
`timescale 1ns/1ps

module host_readback (
   input  logic                clk_x,
   input  logic                reset,
   input  logic                rd_pulse_i,
   input  logic [1:0]          data_sel_i,
   input  logic                data_rd_i,
   input  tart_cfg_pkg::byte_t reg_val_i,
   buffer_if.rdbk              bb,
   output tart_cfg_pkg::byte_t reg_rdata_o,
   output logic                reg_rvalid_o
);

   localparam int BB = tart_cfg_pkg::BYTE_BITS;

   tart_cfg_pkg::byte_t data_byte;
   tart_cfg_pkg::byte_t rdata_d;

   // ------------------------------------------------------------
   // Byte slice of the fetched sample
   // ------------------------------------------------------------
   always_comb begin
      case (data_sel_i)
         2'd0:    data_byte = bb.rd_data[BB-1:0];       // Low byte
         2'd1:    data_byte = bb.rd_data[2*BB-1:BB];
         default: data_byte = bb.rd_data[3*BB-1:2*BB];  // High byte
      endcase
   end

   assign rdata_d = data_rd_i ? data_byte : reg_val_i;

   // Output stage
   always_ff @(posedge clk_x) begin
      if (reset) begin
         reg_rvalid_o <= 1'b0;
      end else begin
         reg_rvalid_o <= rd_pulse_i;   // Second clock after the read strobe
      end
   end

   always_ff @(posedge clk_x) begin
      if (rd_pulse_i) begin
         reg_rdata_o <= rdata_d;
      end
   end

endmodule

// ==== design/sample_buffer.sv ====
`timescale 1ns/1ps

module sample_buffer #(
   parameter int BUF_ADDR_BITS = tart_cfg_pkg::BUF_ADDR_BITS_DEFAULT
) (
   input  logic     clk_x,
   capture_if.store cap,
   buffer_if.mem    bb
);

   localparam int DEPTH = 1 << BUF_ADDR_BITS;   // One acquisition block

   tart_cfg_pkg::sample_t mem [0:DEPTH-1];

   // Write port, one sample per strobe
   always_ff @(posedge clk_x) begin
      if (bb.wr_en) begin
         mem[bb.wr_addr] <= cap.sample;
      end
   end

   // Read port, registered every clock
   always_ff @(posedge clk_x) begin
      bb.rd_data <= mem[bb.rd_addr];
   end

endmodule

// ==== design/sample_clock.sv ====
`timescale 1ns/1ps

module sample_clock #(
   parameter int TRATE = tart_cfg_pkg::TRATE_DEFAULT
) (
   input  logic     clk_x,
   input  logic     reset,
   capture_if.clock cap
);

   // Counter must hold TRATE-1 and every delay setting
   localparam int PH_BITS = (TRATE > 8) ? $clog2(TRATE) : tart_cfg_pkg::DELAY_BITS;
   localparam logic [PH_BITS-1:0] PH_LAST = PH_BITS'(TRATE - 1);

   logic [PH_BITS-1:0] phase_q;
   logic [PH_BITS-1:0] delay_ext;

   // ------------------------------------------------------------
   // Free-running phase counter
   // ------------------------------------------------------------
   always_ff @(posedge clk_x) begin
      if (reset) begin
         phase_q <= '0;
      end else if (phase_q == PH_LAST) begin
         phase_q <= '0;                    // Wrap once per sample
      end else begin
         phase_q <= phase_q + 1'b1;
      end
   end

   // Zero extend the phase setting
   assign delay_ext = PH_BITS'(cap.sample_delay);

   // One clock high per period, at the chosen phase
   assign cap.strobe = (phase_q == delay_ext);

endmodule

// ==== design/tart_cfg_pkg.sv ====
package tart_cfg_pkg;

   // ------------------------------------------------------------
   // Data widths
   // ------------------------------------------------------------
   localparam int SAMPLE_BITS = 24;     // One bit per antenna
   localparam int DELAY_BITS  = 3;      // Sample phase select
   localparam int BYTE_BITS   = 8;      // Host data path
   localparam int ADDR_BITS   = 4;      // Host register space

   typedef logic [SAMPLE_BITS-1:0] sample_t;    // Antenna word
   typedef logic [DELAY_BITS-1:0]  delay_t;     // Strobe phase
   typedef logic [BYTE_BITS-1:0]   byte_t;      // Host byte
   typedef logic [ADDR_BITS-1:0]   reg_addr_t;  // Host register address

   // ------------------------------------------------------------
   // Parameter defaults for the top level
   // ------------------------------------------------------------
   localparam int TRATE_DEFAULT         = 12;   // Clocks per sample
   localparam int BUF_ADDR_BITS_DEFAULT = 9;    // 512 samples per block
   localparam int RESET_CYCLES_DEFAULT  = 4;    // Soft reset length

endpackage

// ==== design/tart_ifs.sv ====
`timescale 1ns/1ps

// Capture path, control settings out and strobe/sample back
interface capture_if;
   tart_cfg_pkg::delay_t  sample_delay;   // Strobe phase
   logic                  debug_mode;     // Fake counter selected
   logic                  strobe;         // One clock per sample period
   tart_cfg_pkg::sample_t sample;         // Selected antenna word

   modport ctrl  (output sample_delay, output debug_mode, input strobe);
   modport clock (input sample_delay, output strobe);
   modport capt  (input debug_mode, input strobe, output sample);
   modport store (input sample);
endinterface

// Block buffer access
interface buffer_if #(
   parameter int ADDR_BITS = tart_cfg_pkg::BUF_ADDR_BITS_DEFAULT
);
   logic                  wr_en;     // Store the current sample
   logic [ADDR_BITS-1:0]  wr_addr;
   logic [ADDR_BITS-1:0]  rd_addr;
   tart_cfg_pkg::sample_t rd_data;   // Registered, one clock after rd_addr

   modport ctrl (output wr_en, output wr_addr, output rd_addr);
   modport mem  (input wr_en, input wr_addr, input rd_addr, output rd_data);
   modport rdbk (input rd_data);
endinterface

// ==== design/tart_regs_pkg.sv ====
package tart_regs_pkg;

   // ------------------------------------------------------------
   // Host register map
   // ------------------------------------------------------------
   // Sample bytes, low to high
   localparam tart_cfg_pkg::reg_addr_t ADDR_DATA_LO  = 4'h0;
   localparam tart_cfg_pkg::reg_addr_t ADDR_DATA_MID = 4'h1;
   localparam tart_cfg_pkg::reg_addr_t ADDR_DATA_HI  = 4'h2;   // Read advances the buffer

   // Control registers
   localparam tart_cfg_pkg::reg_addr_t ADDR_SAMPLE_DELAY = 4'h5;
   localparam tart_cfg_pkg::reg_addr_t ADDR_DEBUG        = 4'h6;  // Fake counter source
   localparam tart_cfg_pkg::reg_addr_t ADDR_START        = 4'h7;
   localparam tart_cfg_pkg::reg_addr_t ADDR_STATUS       = 4'hE;  // Read only
   localparam tart_cfg_pkg::reg_addr_t ADDR_RESET        = 4'hF;  // Write only

   // ------------------------------------------------------------
   // Acquisition FSM
   // ------------------------------------------------------------
   typedef enum logic [2:0] {
      ST_IDLE    = 3'd0,   // Waiting for start
      ST_ACQUIRE = 3'd1,   // Filling the buffer
      ST_READY   = 3'd2,   // Block complete, nothing read yet
      ST_READING = 3'd3    // Host draining the block
   } acq_state_t;

   // Status byte layout, state sits in bits 2..0
   localparam int STAT_ONE   = 7;    // Always set
   localparam int STAT_START = 4;
   localparam int STAT_DEBUG = 3;

endpackage

// ==== design/tart_top.sv ====
`timescale 1ns/1ps

module tart_top #(
   parameter int TRATE         = tart_cfg_pkg::TRATE_DEFAULT,
   parameter int BUF_ADDR_BITS = tart_cfg_pkg::BUF_ADDR_BITS_DEFAULT,
   parameter int RESET_CYCLES  = tart_cfg_pkg::RESET_CYCLES_DEFAULT
) (
   input  logic                    clk_x,
   input  logic                    reset,
   input  tart_cfg_pkg::sample_t   antenna_i,
   input  logic                    reg_wr_i,
   input  logic                    reg_rd_i,
   input  tart_cfg_pkg::reg_addr_t reg_addr_i,
   input  tart_cfg_pkg::byte_t     reg_wdata_i,
   output tart_cfg_pkg::byte_t     reg_rdata_o,
   output logic                    reg_rvalid_o,
   output logic                    led_o
);

   // Control to read-back staging
   logic                rd_pulse;
   logic [1:0]          data_sel;
   logic                data_rd;
   tart_cfg_pkg::byte_t reg_val;

   capture_if cap_bus ();
   buffer_if #(.ADDR_BITS(BUF_ADDR_BITS)) bb_bus ();

   // ------------------------------------------------------------
   // Capture path
   // ------------------------------------------------------------
   sample_clock #(.TRATE(TRATE)) sample_clock_i (
      .clk_x (clk_x), .reset (reset), .cap (cap_bus.clock)
   );

   antenna_capture antenna_capture_i (
      .clk_x (clk_x), .reset (reset), .antenna_i (antenna_i), .cap (cap_bus.capt)
   );

   sample_buffer #(.BUF_ADDR_BITS(BUF_ADDR_BITS)) sample_buffer_i (
      .clk_x (clk_x), .cap (cap_bus.store), .bb (bb_bus.mem)
   );

   // ------------------------------------------------------------
   // Control and host port
   // ------------------------------------------------------------
   acq_control #(.BUF_ADDR_BITS(BUF_ADDR_BITS), .RESET_CYCLES(RESET_CYCLES)) acq_control_i (
      .clk_x       (clk_x),
      .reset       (reset),
      .reg_wr_i    (reg_wr_i),
      .reg_rd_i    (reg_rd_i),
      .reg_addr_i  (reg_addr_i),
      .reg_wdata_i (reg_wdata_i),
      .cap         (cap_bus.ctrl),
      .bb          (bb_bus.ctrl),
      .rd_pulse_o  (rd_pulse),
      .data_sel_o  (data_sel),
      .data_rd_o   (data_rd),
      .reg_val_o   (reg_val),
      .led_o       (led_o)
   );

   host_readback host_readback_i (
      .clk_x (clk_x), .reset (reset), .rd_pulse_i (rd_pulse), .data_sel_i (data_sel),
      .data_rd_i (data_rd), .reg_val_i (reg_val), .bb (bb_bus.rdbk),
      .reg_rdata_o (reg_rdata_o), .reg_rvalid_o (reg_rvalid_o)
   );

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the acquisition core testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
   --top-module tart_tb -f src.f -o tart_sim

obj_dir/tart_sim | tee sim.log

if grep -qF "** PASS **" sim.log; then
   exit 0
fi
exit 1

// ==== src.f ====
design/tart_cfg_pkg.sv
design/tart_regs_pkg.sv
design/tart_ifs.sv
design/sample_clock.sv
design/antenna_capture.sv
design/sample_buffer.sv
design/acq_control.sv
design/host_readback.sv
design/tart_top.sv
tb/tart_assert.sv
tb/tart_tb.sv

// ==== tb/tart_assert.sv ====
`timescale 1ns/1ps

module tart_assert #(
   parameter int ADDR_BITS = tart_cfg_pkg::BUF_ADDR_BITS_DEFAULT
) (
   input logic                      clk_x,
   input logic                      reset,
   input logic                      wr_en_i,
   input logic                      strobe_i,
   input tart_regs_pkg::acq_state_t state_i,
   input logic [ADDR_BITS-1:0]      rd_addr_i,
   input logic                      led_i
);

   // ------------------------------------------------------------
   // Buffer write and read address rules
   // ------------------------------------------------------------
   wr_on_strobe: assert property (@(posedge clk_x) disable iff (reset)
      wr_en_i |-> strobe_i)
      else $error("Buffer write without a sample strobe");

   // Read pointer only moves while draining, or wraps on the way to idle
   rd_addr_moves: assert property (@(posedge clk_x) disable iff (reset)
      (rd_addr_i != $past(rd_addr_i)) |->
         (($past(state_i) == tart_regs_pkg::ST_READING) || (state_i == tart_regs_pkg::ST_IDLE)))
      else $error("Read address changed outside read-back");

   led_state: assert property (@(posedge clk_x) disable iff (reset)
      led_i == ((state_i == tart_regs_pkg::ST_READY) || (state_i == tart_regs_pkg::ST_READING)))
      else $error("led_o does not match the acquisition state");   // Block ready indicator

endmodule

bind acq_control tart_assert #(.ADDR_BITS(BUF_ADDR_BITS)) tart_assert_i (
   .clk_x (clk_x), .reset (reset), .wr_en_i (bb.wr_en), .strobe_i (cap.strobe),
   .state_i (state), .rd_addr_i (rd_addr_q), .led_i (led_o)
);

// ==== tb/tart_tb.sv ====
`timescale 1ns/1ps

module tart_tb;

   localparam int TRATE         = 12;
   localparam int BUF_ADDR_BITS = 3;
   localparam int RESET_CYCLES  = 4;
   localparam int N_SAMPLES     = 1 << BUF_ADDR_BITS;   // One block

   // ------------------------------------------------------------
   // Stimulus table format
   // ------------------------------------------------------------
   localparam logic [1:0] OP_WR  = 2'd0;   // Register write
   localparam logic [1:0] OP_RD  = 2'd1;   // Register read, compare with exp
   localparam logic [1:0] OP_LED = 2'd2;   // Wait until led_o equals exp[0]
   localparam logic [1:0] OP_BUF = 2'd3;   // Drain block, data 0 held word, 1 counter

   typedef struct packed {
      logic [1:0]              kind;
      tart_cfg_pkg::reg_addr_t addr;
      tart_cfg_pkg::byte_t     data;
      tart_cfg_pkg::byte_t     exp;
   } op_t;

   logic                    clk_x;
   logic                    reset;
   tart_cfg_pkg::sample_t   antenna_i;
   logic                    reg_wr_i;
   logic                    reg_rd_i;
   tart_cfg_pkg::reg_addr_t reg_addr_i;
   tart_cfg_pkg::byte_t     reg_wdata_i;
   tart_cfg_pkg::byte_t     reg_rdata_o;
   logic                    reg_rvalid_o;
   logic                    led_o;

   op_t                   ops[$];       // Stimulus table
   tart_cfg_pkg::sample_t ant_word;     // Held on the antenna pins
   integer                seed = 59581;
   int                    errors = 0;
   int                    fails = 0;
   int                    cycles = 0;
   int                    limit = 0;    // Timeout, set once the table is built
   logic                  rd_d1 = 1'b0; // Read strobe history for latency check
   logic                  rd_d2 = 1'b0;

   tart_top #(.TRATE(TRATE), .BUF_ADDR_BITS(BUF_ADDR_BITS), .RESET_CYCLES(RESET_CYCLES)) dut_i (
      .clk_x (clk_x), .reset (reset), .antenna_i (antenna_i),
      .reg_wr_i (reg_wr_i), .reg_rd_i (reg_rd_i), .reg_addr_i (reg_addr_i),
      .reg_wdata_i (reg_wdata_i), .reg_rdata_o (reg_rdata_o),
      .reg_rvalid_o (reg_rvalid_o), .led_o (led_o)
   );

   initial begin
      clk_x = 1'b0;
      forever #20 clk_x = ~clk_x;   // 40 ns period
   end

   // Run limit
   always @(posedge clk_x) begin
      cycles++;
      if (limit > 0 && cycles >= limit) begin
         $display("Run timed out after %0d clock cycles", cycles);
         $display("** FAIL **");
         $finish;
      end
   end

   task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
      if (got !== exp) begin
         $display("Fail %s: got 0x%h, expected 0x%h", name, got, exp);
         errors++;
      end
   endtask

   // Valid must trail each read strobe by exactly two clocks
   always @(negedge clk_x) begin
      if (!reset)
         check_val("reg_rvalid_o", 32'(reg_rvalid_o), 32'(rd_d2));
      rd_d2 = rd_d1;
      rd_d1 = reg_rd_i;
   end

   // ------------------------------------------------------------
   // Host bus helpers
   // ------------------------------------------------------------
   task automatic next_cycle();
      @(posedge clk_x);
      #2;                           // Drive point after the edge
   endtask

   task automatic host_write(input tart_cfg_pkg::reg_addr_t addr,
                             input tart_cfg_pkg::byte_t data);
      reg_addr_i  = addr;
      reg_wdata_i = data;
      reg_wr_i    = 1'b1;
      next_cycle();
      reg_wr_i = 1'b0;
      next_cycle();                 // Two clock strobe spacing
   endtask

   task automatic host_read(input tart_cfg_pkg::reg_addr_t addr,
                            output tart_cfg_pkg::byte_t data);
      reg_addr_i = addr;
      reg_rd_i   = 1'b1;
      next_cycle();
      reg_rd_i = 1'b0;
      next_cycle();                 // Result lands on the second edge
      check_val("reg_rvalid_o", 32'(reg_rvalid_o), 32'h1);
      data = reg_rdata_o;
   endtask

   task automatic add_op(input logic [1:0] kind, input tart_cfg_pkg::reg_addr_t addr,
                         input tart_cfg_pkg::byte_t data, input tart_cfg_pkg::byte_t exp);
      ops.push_back(op_t'{kind, addr, data, exp});
   endtask

   function automatic string op_name(input logic [1:0] kind);
      case (kind)
         OP_WR:   return "write";
         OP_RD:   return "read-check";
         OP_LED:  return "wait-led";
         default: return "read-buffer";
      endcase
   endfunction

   task automatic run_op(input op_t op);
      tart_cfg_pkg::byte_t   rdata;
      tart_cfg_pkg::byte_t   lo, mid, hi;
      tart_cfg_pkg::sample_t word;
      tart_cfg_pkg::sample_t prev;
      tart_cfg_pkg::sample_t expect_word;
      prev = '0;
      case (op.kind)
         OP_WR: host_write(op.addr, op.data);
         OP_RD: begin
            host_read(op.addr, rdata);
            check_val("reg_rdata_o", 32'(rdata), 32'(op.exp));
         end
         OP_LED: begin
            while (led_o !== op.exp[0]) next_cycle();   // Bounded by the run limit
         end
         default: begin
            for (int s = 0; s < N_SAMPLES; s++) begin
               host_read(tart_regs_pkg::ADDR_DATA_LO, lo);
               host_read(tart_regs_pkg::ADDR_DATA_MID, mid);
               host_read(tart_regs_pkg::ADDR_DATA_HI, hi);   // Steps to next sample
               word = {hi, mid, lo};
               if (op.data[0] == 1'b0) begin
                  check_val("sample", 32'(word), 32'(ant_word));
               end else if (s > 0) begin
                  expect_word = prev + 1'b1;   // Wraps at 2^24
                  check_val("sample", 32'(word), 32'(expect_word));
               end
               prev = word;
            end
         end
      endcase
   endtask

   // ------------------------------------------------------------
   // Main sequence
   // ------------------------------------------------------------
   initial begin
      int err_before;
      ant_word    = tart_cfg_pkg::sample_t'($random(seed));
      reset       = 1'b1;
      antenna_i   = ant_word;       // Held for the whole run
      reg_wr_i    = 1'b0;
      reg_rd_i    = 1'b0;
      reg_addr_i  = '0;
      reg_wdata_i = '0;

      // Reset values
      add_op(OP_RD,  tart_regs_pkg::ADDR_STATUS,       8'h00, 8'h80);
      add_op(OP_RD,  tart_regs_pkg::ADDR_SAMPLE_DELAY, 8'h00, 8'h00);
      add_op(OP_LED, tart_regs_pkg::ADDR_STATUS,       8'h00, 8'h00);
      // Register write, read-back, soft reset
      add_op(OP_WR,  tart_regs_pkg::ADDR_SAMPLE_DELAY, 8'h05, 8'h00);
      add_op(OP_WR,  tart_regs_pkg::ADDR_DEBUG,        8'h01, 8'h00);
      add_op(OP_RD,  tart_regs_pkg::ADDR_SAMPLE_DELAY, 8'h00, 8'h05);
      add_op(OP_RD,  tart_regs_pkg::ADDR_DEBUG,        8'h00, 8'h01);
      add_op(OP_RD,  tart_regs_pkg::ADDR_STATUS,       8'h00, 8'h88);   // One and debug
      add_op(OP_WR,  tart_regs_pkg::ADDR_RESET,        8'h01, 8'h00);
      add_op(OP_RD,  tart_regs_pkg::ADDR_SAMPLE_DELAY, 8'h00, 8'h00);
      add_op(OP_RD,  tart_regs_pkg::ADDR_DEBUG,        8'h00, 8'h00);
      add_op(OP_RD,  tart_regs_pkg::ADDR_STATUS,       8'h00, 8'h80);
      // Real antenna capture
      add_op(OP_WR,  tart_regs_pkg::ADDR_START,        8'h01, 8'h00);
      add_op(OP_LED, tart_regs_pkg::ADDR_STATUS,       8'h00, 8'h01);
      add_op(OP_RD,  tart_regs_pkg::ADDR_STATUS,       8'h00, 8'h92);   // Start, ready
      add_op(OP_BUF, tart_regs_pkg::ADDR_DATA_LO,      8'h00, 8'h00);
      add_op(OP_RD,  tart_regs_pkg::ADDR_STATUS,       8'h00, 8'h80);   // Back to idle
      add_op(OP_LED, tart_regs_pkg::ADDR_STATUS,       8'h00, 8'h00);
      // Fake counter capture
      add_op(OP_WR,  tart_regs_pkg::ADDR_DEBUG,        8'h01, 8'h00);
      add_op(OP_WR,  tart_regs_pkg::ADDR_START,        8'h01, 8'h00);
      add_op(OP_LED, tart_regs_pkg::ADDR_STATUS,       8'h00, 8'h01);
      add_op(OP_RD,  tart_regs_pkg::ADDR_STATUS,       8'h00, 8'h9A);
      add_op(OP_BUF, tart_regs_pkg::ADDR_DATA_LO,      8'h01, 8'h00);
      add_op(OP_RD,  tart_regs_pkg::ADDR_STATUS,       8'h00, 8'h88);   // Debug stays set
      add_op(OP_LED, tart_regs_pkg::ADDR_STATUS,       8'h00, 8'h00);
      limit = ops.size() * 4 + 3 * N_SAMPLES * TRATE + 100;

      repeat (2) @(posedge clk_x);
      #2;
      reset = 1'b0;

      foreach (ops[i]) begin
         err_before = errors;
         run_op(ops[i]);
         if (errors == err_before) begin
            $display("Test %0d %s addr 0x%h: ok", i, op_name(ops[i].kind), ops[i].addr);
         end else begin
            $display("Test %0d %s addr 0x%h: failed", i, op_name(ops[i].kind), ops[i].addr);
            fails++;
         end
      end

      $display("Tests run %0d, tests failed %0d, errors %0d", ops.size(), fails, errors);
      if (errors == 0)
         $display("** PASS **");
      else
         $display("** FAIL **");
      $finish;
   end

endmodule
